// ==== verilog/trace_checker_pkg.sv ====
package trace_checker_pkg;

    ////////////////////////////////////////
    // Line format codes on format_type
    ////////////////////////////////////////

    localparam logic [1:0] format_none = 2'd0;
    localparam logic [1:0] format_reg  = 2'd1;
    localparam logic [1:0] format_mem  = 2'd2;

    ////////////////////////////////////////
    // Bit positions in error_code
    ////////////////////////////////////////

    localparam int err_time = 0;
    localparam int err_pc   = 1;
    localparam int err_addr = 2;
    localparam int err_reg  = 3;

    ////////////////////////////////////////
    // Field digit limits
    ////////////////////////////////////////

    // Decimal fields take 1 up to this many digits
    localparam int max_dec_digits = 4;
    // Hex fields take exactly this many
    localparam int hex_digits = 8;

    ////////////////////////////////////////
    // Field after "$" or "*"
    ////////////////////////////////////////

    // Register view, anything above the low 5 bits is out of range
    typedef struct packed {
        logic [26:0] upper;
        logic [4:0]  reg_index;
    } reg_view_t;

    typedef union packed {
        logic [31:0] mem_addr;
        reg_view_t   reg_view;
    } target_word_t;

endpackage

// ==== verilog/char_decoder.sv ====
module char_decoder (
    input  logic [7:0] char,
    output logic       is_dec,
    output logic       is_hex,
    output logic [3:0] digit_value
);

    logic in_num;
    logic in_lower;
    logic in_upper;

    // Character class ranges
    assign in_num   = (char >= "0") && (char <= "9");
    assign in_lower = (char >= "a") && (char <= "f");
    assign in_upper = (char >= "A") && (char <= "F");

    always_comb begin
        is_dec      = 1'b0;
        is_hex      = 1'b0;
        digit_value = 4'd0;
        if (in_num) begin
            is_dec      = 1'b1;
            is_hex      = 1'b1;
            digit_value = char[3:0];
        end else if (in_lower || in_upper) begin
            // Low nibble of 'a'/'A' is 1, so add 9 to reach 10
            is_hex      = 1'b1;
            digit_value = char[3:0] + 4'd9;
        end
    end

endmodule

// ==== verilog/line_parser.sv ====
module line_parser (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [7:0]                      char,
    input  logic                            is_dec,
    input  logic                            is_hex,
    input  logic [3:0]                      digit_value,
    output logic                            line_done,
    output logic                            line_is_mem,
    output logic [15:0]                     time_value,
    output logic [31:0]                     pc_value,
    output trace_checker_pkg::target_word_t target
);

    ////////////////////////////////////////
    // FSM states
    ////////////////////////////////////////

    localparam logic [3:0] st_idle     = 4'd0;
    localparam logic [3:0] st_time     = 4'd1;
    localparam logic [3:0] st_pc       = 4'd2;
    localparam logic [3:0] st_colon    = 4'd3;
    localparam logic [3:0] st_reg      = 4'd4;
    localparam logic [3:0] st_addr     = 4'd5;
    localparam logic [3:0] st_pre_lt   = 4'd6;
    localparam logic [3:0] st_eq       = 4'd7;
    localparam logic [3:0] st_pre_data = 4'd8;
    localparam logic [3:0] st_data     = 4'd9;

    localparam logic [3:0] dec_limit = 4'(trace_checker_pkg::max_dec_digits);
    localparam logic [3:0] hex_limit = 4'(trace_checker_pkg::hex_digits);

    logic [3:0] state;
    logic [3:0] digit_count;
    logic       restart;
    logic       dec_room;
    logic       dec_have;
    logic       hex_room;
    logic       hex_full;

    // No state accepts a caret, so one always opens a fresh line
    assign restart  = (char == "^");

    assign dec_room = (digit_count < dec_limit);
    assign dec_have = (digit_count != 4'd0);
    assign hex_room = (digit_count < hex_limit);
    assign hex_full = (digit_count == hex_limit);

    // Closing mark of a complete line
    assign line_done = (state == st_data) && (char == "#") && hex_full;

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            digit_count <= 4'd0;
            line_is_mem <= 1'b0;
        end else if (restart) begin
            state       <= st_time;
            digit_count <= 4'd0;
        end else begin
            state       <= st_idle;
            digit_count <= 4'd0;
            case (state)
                st_time: begin
                    if (is_dec && dec_room) begin
                        state       <= st_time;
                        digit_count <= digit_count + 4'd1;
                    end else if (char == "@" && dec_have) begin
                        state <= st_pc;
                    end
                end
                st_pc: begin
                    if (is_hex && hex_room) begin
                        state       <= st_pc;
                        digit_count <= digit_count + 4'd1;
                    end else if (char == ":" && hex_full) begin
                        state <= st_colon;
                    end
                end
                st_colon: begin
                    if (char == " ") begin
                        state <= st_colon;
                    end else if (char == "$") begin
                        state       <= st_reg;
                        line_is_mem <= 1'b0;
                    end else if (char == "*") begin
                        state       <= st_addr;
                        line_is_mem <= 1'b1;
                    end
                end
                st_reg: begin
                    if (is_dec && dec_room) begin
                        state       <= st_reg;
                        digit_count <= digit_count + 4'd1;
                    end else if (char == " " && dec_have) begin
                        state <= st_pre_lt;
                    end else if (char == "<" && dec_have) begin
                        state <= st_eq;
                    end
                end
                st_addr: begin
                    if (is_hex && hex_room) begin
                        state       <= st_addr;
                        digit_count <= digit_count + 4'd1;
                    end else if (char == " " && hex_full) begin
                        state <= st_pre_lt;
                    end else if (char == "<" && hex_full) begin
                        state <= st_eq;
                    end
                end
                st_pre_lt: begin
                    if (char == " ") begin
                        state <= st_pre_lt;
                    end else if (char == "<") begin
                        state <= st_eq;
                    end
                end
                st_eq: begin
                    if (char == "=") begin
                        state <= st_pre_data;
                    end
                end
                st_pre_data: begin
                    if (char == " ") begin
                        state <= st_pre_data;
                    end else if (is_hex) begin
                        state       <= st_data;
                        digit_count <= 4'd1;
                    end
                end
                st_data: begin
                    // Data is only counted, its value is not kept
                    if (is_hex && hex_room) begin
                        state       <= st_data;
                        digit_count <= digit_count + 4'd1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Field accumulation
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (restart) begin
            time_value <= 16'd0;
        end else if (state == st_time && is_dec && dec_room) begin
            time_value <= time_value * 16'd10 + 16'(digit_value);
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_pc && is_hex && hex_room) begin
            pc_value <= {pc_value[27:0], digit_value};
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_colon && (char == "$" || char == "*")) begin
            target.mem_addr <= 32'd0;
        end else if (state == st_reg && is_dec && dec_room) begin
            // Register number lands zero-extended in the full word
            target.mem_addr <= target.mem_addr * 32'd10 + 32'(digit_value);
        end else if (state == st_addr && is_hex && hex_room) begin
            target.mem_addr <= {target.mem_addr[27:0], digit_value};
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    line_done_single: assert property (
        @(posedge clk) disable iff (reset) line_done |=> !line_done
    );

    digit_count_bound: assert property (
        @(posedge clk) disable iff (reset) digit_count <= hex_limit
    );

endmodule

// ==== verilog/field_checker.sv ====
module field_checker #(
    parameter logic [31:0] pc_low    = 32'h0000_3000,
    parameter logic [31:0] pc_high   = 32'h0000_4fff,
    parameter logic [31:0] addr_high = 32'h0000_2fff
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [15:0]                     freq,
    input  logic                            line_done,
    input  logic                            line_is_mem,
    input  logic [15:0]                     time_value,
    input  logic [31:0]                     pc_value,
    input  trace_checker_pkg::target_word_t target,
    output logic [1:0]                      format_type,
    output logic [3:0]                      error_code
);

    logic [15:0] time_mask;
    logic [3:0]  err_bits;
    logic [1:0]  line_format;

    // freq is a power of two, so freq/2 - 1 masks the low bits
    assign time_mask = (freq >> 1) - 16'd1;

    always_comb begin
        err_bits = 4'd0;
        err_bits[trace_checker_pkg::err_time] = |(time_value & time_mask);
        err_bits[trace_checker_pkg::err_pc] = (pc_value < pc_low)
                                            || (pc_value > pc_high)
                                            || (pc_value[1:0] != 2'b00);
        if (line_is_mem) begin
            err_bits[trace_checker_pkg::err_addr] = (target.mem_addr > addr_high)
                                                  || (target.mem_addr[1:0] != 2'b00);
        end else begin
            err_bits[trace_checker_pkg::err_reg] = |target.reg_view.upper;
        end
    end

    assign line_format = line_is_mem ? trace_checker_pkg::format_mem
                                     : trace_checker_pkg::format_reg;

    ////////////////////////////////////////
    // One-cycle result pulse
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            format_type <= trace_checker_pkg::format_none;
            error_code  <= 4'd0;
        end else if (line_done) begin
            format_type <= line_format;
            error_code  <= err_bits;
        end else begin
            format_type <= trace_checker_pkg::format_none;
            error_code  <= 4'd0;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    idle_code_clear: assert property (
        @(posedge clk) disable iff (reset)
        (format_type == trace_checker_pkg::format_none) |-> (error_code == 4'd0)
    );

endmodule

// ==== verilog/trace_checker.sv ====
module trace_checker #(
    parameter logic [31:0] pc_low    = 32'h0000_3000,
    parameter logic [31:0] pc_high   = 32'h0000_4fff,
    parameter logic [31:0] addr_high = 32'h0000_2fff
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  char,
    input  logic [15:0] freq,
    output logic [1:0]  format_type,
    output logic [3:0]  error_code
);

    logic                            is_dec;
    logic                            is_hex;
    logic [3:0]                      digit_value;
    logic                            line_done;
    logic                            line_is_mem;
    logic [15:0]                     time_value;
    logic [31:0]                     pc_value;
    trace_checker_pkg::target_word_t target;

    char_decoder u_char_decoder (
        .char        (char),
        .is_dec      (is_dec),
        .is_hex      (is_hex),
        .digit_value (digit_value)
    );

    line_parser u_line_parser (
        .clk         (clk),
        .reset       (reset),
        .char        (char),
        .is_dec      (is_dec),
        .is_hex      (is_hex),
        .digit_value (digit_value),
        .line_done   (line_done),
        .line_is_mem (line_is_mem),
        .time_value  (time_value),
        .pc_value    (pc_value),
        .target      (target)
    );

    // Address windows come from here
    field_checker #(
        .pc_low    (pc_low),
        .pc_high   (pc_high),
        .addr_high (addr_high)
    ) u_field_checker (
        .clk         (clk),
        .reset       (reset),
        .freq        (freq),
        .line_done   (line_done),
        .line_is_mem (line_is_mem),
        .time_value  (time_value),
        .pc_value    (pc_value),
        .target      (target),
        .format_type (format_type),
        .error_code  (error_code)
    );

endmodule

// ==== test/tb_trace_checker.sv ====
module tb_trace_checker;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    result_window = 20;
    localparam string test_file     = "test/trace_checker_tests.txt";

    logic        clk;
    logic        reset;
    logic [7:0]  char_in;
    logic [15:0] freq;
    logic [1:0]  format_type;
    logic [3:0]  error_code;

    int         mismatches;
    int         failures;
    int         pulses_seen;
    logic [1:0] exp_format;
    logic [3:0] exp_error;
    logic       last_pulse;

    trace_checker DUT (
        .clk         (clk),
        .reset       (reset),
        .char        (char_in),
        .freq        (freq),
        .format_type (format_type),
        .error_code  (error_code)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Registered outputs, looked at once per cycle
    task automatic observe_outputs();
        if (format_type != trace_checker_pkg::format_none) begin
            pulses_seen++;
            if (last_pulse) begin
                failures++;
                $display("Result pulse lasted longer than one cycle");
            end
            check_value("format_type", 32'(format_type), 32'(exp_format));
            check_value("error_code", 32'(error_code), 32'(exp_error));
            last_pulse = 1'b1;
        end else begin
            check_value("error_code", 32'(error_code), 32'd0);
            last_pulse = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic drive_char(input logic [7:0] c);
        @(posedge clk);
        #1;
        observe_outputs();
        char_in = c;
    endtask

    // Noise between lines, never a caret
    task automatic drive_filler();
        int         count;
        logic [7:0] c;
        count = int'($urandom_range(5, 0));
        for (int i = 0; i < count; i++) begin
            c = 8'($urandom_range(126, 32));
            if (c == "^") begin
                c = "~";
            end
            drive_char(c);
        end
    endtask

    task automatic wait_result(input int expected);
        int cycles;
        cycles = 0;
        while (cycles < result_window && !(expected != 0 && pulses_seen >= expected)) begin
            drive_char(" ");
            cycles++;
        end
        if (expected != 0 && pulses_seen < expected) begin
            failures++;
            $display("Timeout: result pulse missing %0d cycles after the line end",
                     result_window);
        end else begin
            check_value("pulse_count", 32'(pulses_seen), 32'(expected));
        end
    endtask

    task automatic run_record(input string text, input int pulses);
        pulses_seen = 0;
        drive_filler();
        for (int i = 0; i < text.len(); i++) begin
            drive_char(text.getc(i));
        end
        wait_result(pulses);
    endtask

    ////////////////////////////////////////
    // Record parsing
    ////////////////////////////////////////

    function automatic logic is_blank(input byte c);
        return (c == " ") || (c == "\t") || (c == "\n") || (c == "\r");
    endfunction

    // Skip the four leading columns, keep the trace text
    function automatic string line_text(input string s);
        int idx;
        int last;
        idx = 0;
        for (int t = 0; t < 4; t++) begin
            while (idx < s.len() && is_blank(s.getc(idx))) idx++;
            while (idx < s.len() && !is_blank(s.getc(idx))) idx++;
        end
        while (idx < s.len() && is_blank(s.getc(idx))) idx++;
        last = s.len() - 1;
        while (last >= idx && is_blank(s.getc(last))) last--;
        return s.substr(idx, last);
    endfunction

    initial begin
        int          fd;
        int          fields;
        int          records;
        int          rec_format;
        int          rec_error;
        int          rec_pulses;
        logic [15:0] rec_freq;
        string       line;
        clk         = 1'b0;
        reset       = 1'b1;
        char_in     = 8'h20;
        freq        = 16'd2;
        mismatches  = 0;
        failures    = 0;
        pulses_seen = 0;
        exp_format  = 2'd0;
        exp_error   = 4'd0;
        last_pulse  = 1'b0;
        records     = 0;
        void'($urandom(96));

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen(test_file, "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the test data file %s", test_file);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    fields = $sscanf(line, "%h %d %h %d", rec_freq, rec_format,
                                     rec_error, rec_pulses);
                    if (fields == 4) begin
                        freq       = rec_freq;
                        exp_format = 2'(rec_format);
                        exp_error  = 4'(rec_error);
                        run_record(line_text(line), rec_pulses);
                        records++;
                    end
                end
            end
            $fclose(fd);
            if (records == 0) begin
                failures++;
                $display("No test records found in %s", test_file);
            end
        end

        $display("Done: %0d records, %0d mismatches, %0d other failures",
                 records, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== test/trace_checker_tests.txt ====
// freq(hex) format error(hex) pulses trace-text
// format 0 none, 1 reg, 2 mem; error bits time=1 pc=2 addr=4 reg=8
2   1 0 1 ^10@00003000: $1 <= 0000000A#
2   2 0 1 ^25@00003ffc: *00002ffc <= DEADbeef#
4   1 0 1 ^4@000040aC:   $31<=  12345678#
10  2 0 1 ^9992@00004FFC: *00000000    <=0000ffff#
8   1 0 1 ^0@00003004:$0 <= FFFFFFFF#
// time not a multiple of freq/2
4   1 1 1 ^7@00003000: $2 <= 00000001#
10  1 1 1 ^12@00003000: $2 <= 00000001#
100 2 1 1 ^64@00003000: *00000100 <= 00000001#
100 2 0 1 ^1280@00003000: *00000100 <= 00000001#
// pc range and alignment
2   1 2 1 ^10@00002ffc: $3 <= 00000000#
2   1 2 1 ^10@00005000: $3 <= 00000000#
2   1 2 1 ^10@00003002: $3 <= 00000000#
// addr range and alignment
2   2 4 1 ^10@00003000: *00003000 <= 00000000#
2   2 4 1 ^10@00003000: *00000001 <= 00000000#
// reg out of range
2   1 8 1 ^10@00003000: $32 <= 00000000#
2   1 8 1 ^10@00003000: $9999 <= 00000000#
// several rules broken at once
4   1 b 1 ^3@00001000: $40 <= 00000000#
8   2 7 1 ^5@00004ffe: *12345678 <= 00000000#
// syntax faults, dropped silently
2   0 0 0 ^10 00003000: $1 <= 00000000#
2   0 0 0 ^10@0000300: $1 <= 00000000#
2   0 0 0 ^10@000030000: $1 <= 00000000#
2   0 0 0 ^10@00003000: $1 <= 0000000#
2   0 0 0 ^10@00003000: $1 <= 000000000#
2   0 0 0 ^12345@00003000: $1 <= 00000000#
2   0 0 0 ^10@00003000: $1 < 00000000#
2   0 0 0 ^10@00003000: x$1 <= 00000000#
2   0 0 0 ^10@00003000: *000000000 <= 00000000#
// recovery on a fresh caret
2   1 0 1 ^10@0000300^20@00003008: $4 <= 0000abcd#
2   2 0 1 ^10@00003000: *^30@00003010: *00000010 <= 11111111#
// back to back
2   1 0 2 ^10@00003000: $1 <= 00000001#^11@00003004: $2 <= 00000002#

// ==== build.f ====
verilog/trace_checker_pkg.sv
verilog/char_decoder.sv
verilog/line_parser.sv
verilog/field_checker.sv
verilog/trace_checker.sv
test/tb_trace_checker.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_trace_checker
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' build.f)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) build.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f build.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || \
		(echo "No pass message found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
